// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_db_req \
		-f src.f -Mdir obj_dir -o tb_db_req

run: compile
	./obj_dir/tb_db_req > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== db_req_top.sv ====
// RapidIO initiator request controller top level
// Connects user FIFO, request FSM, response decoder and timer

`timescale 1ns/1ps

module db_req_top import srio_pkg::*, req_ctrl_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 65536,
    parameter int FIFO_DEPTH     = 512
) (
    input  logic       log_clk,
    input  logic       log_rst,
    input  dev_id_t    src_id_i,
    input  dev_id_t    des_id_i,
    input  logic       self_check_i,
    input  logic       nwr_req_i,
    input  logic       link_initialized_i,
    input  logic       user_tvalid_i,
    input  logic       user_tfirst_i,
    input  logic       user_tlast_i,
    input  srio_data_t user_tdata_i,
    input  srio_keep_t user_tkeep_i,
    input  logic [7:0] user_tsize_i,
    output logic       user_tready_o,
    output logic       rapidio_ready_o,
    output logic       nwr_ready_o,
    output logic       nwr_busy_o,
    output logic       nwr_ack_done_o,
    output logic       error_o,
    output err_type_t  error_type_o,
    output logic       ireq_tvalid_o,
    input  logic       ireq_tready_i,
    output logic       ireq_tlast_o,
    output srio_data_t ireq_tdata_o,
    output srio_keep_t ireq_tkeep_o,
    output srio_user_t ireq_tuser_o,
    input  logic       iresp_tvalid_i,
    output logic       iresp_tready_o,
    input  logic       iresp_tlast_i,
    input  srio_data_t iresp_tdata_i,
    input  srio_keep_t iresp_tkeep_i,
    input  srio_user_t iresp_tuser_i
);

    logic       fifo_wr_en;
    srio_data_t fifo_wr_data;
    logic       fifo_full;
    logic       fifo_empty;
    logic       fifo_pop;
    logic       fifo_first;
    logic       fifo_last;
    srio_data_t fifo_data;
    srio_keep_t fifo_keep;
    logic       resp_valid;
    logic       resp_ready;
    logic       resp_busy;
    logic       resp_confirm;
    db_info_t   expected_info;
    logic       timer_run;
    logic       timeout;

    // Header beat stores only the packet size
    assign fifo_wr_data  = user_tfirst_i ? {56'h0, user_tsize_i} : user_tdata_i;
    assign fifo_wr_en    = user_tvalid_i && !fifo_full;
    assign user_tready_o = !fifo_full;

    // Doorbell responses arrive as single full beats
    assign resp_valid     = iresp_tvalid_i && iresp_tlast_i && (&iresp_tkeep_i);
    assign iresp_tready_o = 1'b1;

    user_data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .log_clk(log_clk), .log_rst(log_rst),
        .wr_en_i(fifo_wr_en), .wr_first_i(user_tfirst_i), .wr_last_i(user_tlast_i),
        .wr_data_i(fifo_wr_data), .wr_keep_i(user_tkeep_i), .rd_en_i(fifo_pop),
        .full_o(fifo_full), .empty_o(fifo_empty), .rd_first_o(fifo_first),
        .rd_last_o(fifo_last), .rd_data_o(fifo_data), .rd_keep_o(fifo_keep)
    );

    req_ctrl u_ctrl (
        .log_clk(log_clk), .log_rst(log_rst),
        .src_id_i(src_id_i), .des_id_i(des_id_i),
        .self_check_i(self_check_i), .nwr_req_i(nwr_req_i),
        .link_initialized_i(link_initialized_i),
        .fifo_empty_i(fifo_empty), .fifo_first_i(fifo_first), .fifo_last_i(fifo_last),
        .fifo_data_i(fifo_data), .fifo_keep_i(fifo_keep),
        .ireq_tready_i(ireq_tready_i),
        .resp_ready_i(resp_ready), .resp_busy_i(resp_busy), .resp_confirm_i(resp_confirm),
        .timeout_i(timeout),
        .fifo_pop_o(fifo_pop), .timer_run_o(timer_run), .expected_info_o(expected_info),
        .ireq_tvalid_o(ireq_tvalid_o), .ireq_tlast_o(ireq_tlast_o),
        .ireq_tdata_o(ireq_tdata_o), .ireq_tkeep_o(ireq_tkeep_o), .ireq_tuser_o(ireq_tuser_o),
        .rapidio_ready_o(rapidio_ready_o), .nwr_ready_o(nwr_ready_o),
        .nwr_busy_o(nwr_busy_o), .nwr_ack_done_o(nwr_ack_done_o),
        .error_o(error_o), .error_type_o(error_type_o)
    );

    resp_decoder u_dec (
        .iresp_tvalid_i(resp_valid), .iresp_tdata_i(iresp_tdata_i),
        .iresp_tuser_i(iresp_tuser_i), .des_id_i(des_id_i),
        .expected_info_i(expected_info),
        .resp_ready_o(resp_ready), .resp_busy_o(resp_busy), .resp_confirm_o(resp_confirm)
    );

    resp_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timer (
        .log_clk(log_clk), .log_rst(log_rst),
        .run_i(timer_run), .timeout_o(timeout)
    );

endmodule

// ==== req_ctrl.sv ====
// Request FSM with ireq beat building and status flags
// Alternating TID, target address and confirmation code

`timescale 1ns/1ps

module req_ctrl import srio_pkg::*, req_ctrl_pkg::*; (
    input  logic       log_clk,
    input  logic       log_rst,
    input  dev_id_t    src_id_i,
    input  dev_id_t    des_id_i,
    input  logic       self_check_i,
    input  logic       nwr_req_i,
    input  logic       link_initialized_i,
    input  logic       fifo_empty_i,
    input  logic       fifo_first_i,
    input  logic       fifo_last_i,
    input  srio_data_t fifo_data_i,
    input  srio_keep_t fifo_keep_i,
    input  logic       ireq_tready_i,
    input  logic       resp_ready_i,
    input  logic       resp_busy_i,
    input  logic       resp_confirm_i,
    input  logic       timeout_i,
    output logic       fifo_pop_o,
    output logic       timer_run_o,
    output db_info_t   expected_info_o,
    output logic       ireq_tvalid_o,
    output logic       ireq_tlast_o,
    output srio_data_t ireq_tdata_o,
    output srio_keep_t ireq_tkeep_o,
    output srio_user_t ireq_tuser_o,
    output logic       rapidio_ready_o,
    output logic       nwr_ready_o,
    output logic       nwr_busy_o,
    output logic       nwr_ack_done_o,
    output logic       error_o,
    output err_type_t  error_type_o
);

    req_state_t state_q;
    req_state_t state_d;
    logic       alt_q;
    logic       ireq_xfer;
    logic       ack_hit;
    logic       db_timeout;
    logic       ack_timeout;
    srio_addr_t target_addr;
    srio_data_t nwr_header;

    // Single-beat doorbell carrying the given information field
    function automatic srio_data_t db_beat(input db_info_t info);
        return {8'h00, FTYPE_DOORBELL, 4'h0, 1'b0, REQ_PRIO, 1'b0, 12'h000, info, 16'h0000};
    endfunction

    assign ireq_xfer = ireq_tvalid_o && ireq_tready_i;

    assign ack_hit     = (state_q == WAIT_ACK) && resp_confirm_i;
    assign ack_timeout = (state_q == WAIT_ACK) && timeout_i && !resp_confirm_i;
    assign db_timeout  = (state_q == DB_RESP) && timeout_i && !resp_ready_i && !resp_busy_i;

    assign target_addr     = alt_q ? TARGET_ADDR_ODD : TARGET_ADDR_EVEN;
    assign expected_info_o = alt_q ? DB_INFO_CONFIRM_ODD : DB_INFO_CONFIRM_EVEN;

    // TID carries the alternating bit in its low bit
    assign nwr_header = {7'h00, alt_q, FTYPE_NWRITE, TTYPE_NWRITE, 1'b0, REQ_PRIO, 1'b0,
                         fifo_data_i[7:0], 2'b00, target_addr};

    assign fifo_pop_o      = (state_q == NWR) && ireq_xfer;
    assign timer_run_o     = (state_q == DB_RESP) || (state_q == WAIT_ACK);
    assign rapidio_ready_o = (state_q == IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Self-check wins over a pending NWRITE
                if (self_check_i && link_initialized_i) begin
                    state_d = DB_REQ;
                end else if (nwr_req_i && link_initialized_i) begin
                    state_d = NWR;
                end
            end
            DB_REQ: begin
                if (ireq_xfer) begin
                    state_d = DB_RESP;
                end
            end
            DB_RESP: begin
                if (resp_ready_i || resp_busy_i || timeout_i) begin
                    state_d = IDLE;
                end
            end
            NWR: begin
                if (ireq_xfer && fifo_last_i) begin
                    state_d = INTEG_DB;
                end
            end
            INTEG_DB: begin
                if (ireq_xfer) begin
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (resp_confirm_i || timeout_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            state_q        <= IDLE;
            alt_q          <= 1'b0;
            nwr_ready_o    <= 1'b0;
            nwr_busy_o     <= 1'b0;
            nwr_ack_done_o <= 1'b0;
            error_o        <= 1'b0;
            error_type_o   <= ERR_NONE;
        end else begin
            state_q        <= state_d;
            nwr_ack_done_o <= ack_hit;
            error_o        <= db_timeout || ack_timeout;
            if (db_timeout) begin
                error_type_o <= ERR_DB_TIMEOUT;
            end else if (ack_timeout) begin
                error_type_o <= ERR_ACK_TIMEOUT;
            end else begin
                error_type_o <= ERR_NONE;
            end
            // Next transfer uses the other TID, address and code
            if (ack_hit) begin
                alt_q <= ~alt_q;
            end
            if (state_q == IDLE && state_d == DB_REQ) begin
                nwr_ready_o <= 1'b0;
                nwr_busy_o  <= 1'b0;
            end else if (state_q == DB_RESP) begin
                if (resp_ready_i) begin
                    nwr_ready_o <= 1'b1;
                end else if (resp_busy_i) begin
                    nwr_busy_o <= 1'b1;
                end
            end
        end
    end

    // Beat contents depend only on state and FIFO head, so they hold under stall
    always_comb begin
        ireq_tvalid_o = 1'b0;
        ireq_tlast_o  = 1'b0;
        ireq_tdata_o  = '0;
        ireq_tkeep_o  = '1;
        ireq_tuser_o  = {src_id_i, des_id_i};
        case (state_q)
            DB_REQ: begin
                ireq_tvalid_o = 1'b1;
                ireq_tlast_o  = 1'b1;
                ireq_tdata_o  = db_beat(DB_INFO_SELF_CHECK);
            end
            NWR: begin
                ireq_tvalid_o = !fifo_empty_i;
                ireq_tlast_o  = fifo_last_i;
                ireq_tkeep_o  = fifo_keep_i;
                ireq_tdata_o  = fifo_first_i ? nwr_header : fifo_data_i;
            end
            INTEG_DB: begin
                ireq_tvalid_o = 1'b1;
                ireq_tlast_o  = 1'b1;
                ireq_tdata_o  = db_beat(expected_info_o);
            end
            default: ;
        endcase
    end

    a_ireq_stable: assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_o && !ireq_tready_i |=> ireq_tvalid_o && $stable(ireq_tdata_o)
            && $stable(ireq_tlast_o) && $stable(ireq_tkeep_o));

endmodule

// ==== req_ctrl_pkg.sv ====
// Request controller states, error codes and doorbell information codes
// Alternating target addresses for the NWRITE transfers

package req_ctrl_pkg;

    import srio_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        DB_REQ,
        DB_RESP,
        NWR,
        INTEG_DB,
        WAIT_ACK
    } req_state_t;

    typedef logic [1:0] err_type_t;

    localparam err_type_t ERR_NONE        = 2'd0;
    localparam err_type_t ERR_DB_TIMEOUT  = 2'd1;
    localparam err_type_t ERR_ACK_TIMEOUT = 2'd2;

    // Doorbell information codes
    localparam db_info_t DB_INFO_SELF_CHECK   = 16'h0001;
    localparam db_info_t DB_INFO_READY        = 16'h0100;
    localparam db_info_t DB_INFO_BUSY         = 16'h01FF;
    localparam db_info_t DB_INFO_CONFIRM_EVEN = 16'h0003;
    localparam db_info_t DB_INFO_CONFIRM_ODD  = 16'h0002;

    localparam srio_addr_t TARGET_ADDR_EVEN = 34'h0_8100_0000;
    localparam srio_addr_t TARGET_ADDR_ODD  = 34'h0_0010_0000;

endpackage

// ==== resp_decoder.sv ====
// Doorbell response classifier
// Flags ready, busy and confirmation answers from the target endpoint

`timescale 1ns/1ps

module resp_decoder import srio_pkg::*, req_ctrl_pkg::*; (
    input  logic       iresp_tvalid_i,
    input  srio_data_t iresp_tdata_i,
    input  srio_user_t iresp_tuser_i,
    input  dev_id_t    des_id_i,
    input  db_info_t   expected_info_i,
    output logic       resp_ready_o,
    output logic       resp_busy_o,
    output logic       resp_confirm_o
);

    ftype_t   resp_ftype;
    db_info_t resp_info;
    dev_id_t  resp_src_id;
    logic     resp_hit;

    assign resp_ftype  = iresp_tdata_i[55:52];
    assign resp_info   = iresp_tdata_i[31:16];
    assign resp_src_id = iresp_tuser_i[31:16];

    // Only doorbells sent back by the addressed endpoint count
    assign resp_hit = iresp_tvalid_i && (resp_ftype == FTYPE_DOORBELL)
                      && (resp_src_id == des_id_i);

    assign resp_ready_o   = resp_hit && (resp_info == DB_INFO_READY);
    assign resp_busy_o    = resp_hit && (resp_info == DB_INFO_BUSY);
    assign resp_confirm_o = resp_hit && (resp_info == expected_info_i);

    // Expected code from the controller must never alias ready or busy
    always_comb begin
        a_onehot_class: assert ($onehot0({resp_ready_o, resp_busy_o, resp_confirm_o}))
            else $error("resp_decoder: overlapping response classes");
    end

endmodule

// ==== resp_timer.sv ====
// Response timer
// Counts cycles while a response is awaited and pulses on expiry

`timescale 1ns/1ps

module resp_timer #(
    parameter int TIMEOUT_CYCLES = 65536
) (
    input  logic log_clk,
    input  logic log_rst,
    input  logic run_i,
    output logic timeout_o
);

    localparam int CNT_W = (TIMEOUT_CYCLES > 1) ? $clog2(TIMEOUT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(TIMEOUT_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            cnt       <= '0;
            timeout_o <= 1'b0;
        end else if (!run_i) begin
            cnt       <= '0;
            timeout_o <= 1'b0;
        end else if (cnt == LAST_CNT) begin
            // Expired, start a fresh interval
            cnt       <= '0;
            timeout_o <= 1'b1;
        end else begin
            cnt       <= cnt + 1'b1;
            timeout_o <= 1'b0;
        end
    end

endmodule

// ==== src.f ====
+incdir+.
srio_pkg.sv
req_ctrl_pkg.sv
user_data_fifo.sv
resp_decoder.sv
resp_timer.sv
req_ctrl.sv
db_req_top.sv
tb_db_req.sv

// ==== srio_pkg.sv ====
// RapidIO stream beat and field types
// Format, transaction type and priority codes used in request headers

package srio_pkg;

    // One 64-bit beat on the ireq and iresp streams
    typedef logic [63:0] srio_data_t;

    // Byte enables of a beat
    typedef logic [7:0] srio_keep_t;

    // Source ID in the upper half, destination ID in the lower half
    typedef logic [31:0] srio_user_t;

    typedef logic [15:0] dev_id_t;

    typedef logic [33:0] srio_addr_t;

    typedef logic [15:0] db_info_t;

    typedef logic [3:0] ftype_t;

    typedef logic [3:0] ttype_t;

    // Format codes
    localparam ftype_t FTYPE_DOORBELL = 4'hA;
    localparam ftype_t FTYPE_NWRITE   = 4'h5;

    // Transaction type for NWRITE without response
    localparam ttype_t TTYPE_NWRITE = 4'h4;

    // Priority of every request sent by the initiator
    localparam logic [1:0] REQ_PRIO = 2'h1;

endpackage

// ==== tb_checks.svh ====
// Expected-beat model for the ireq stream
// Error counters and the value and condition checks

typedef struct packed {
    logic [63:0] data;
    logic [63:0] mask;
    logic [7:0]  keep;
    logic        chk_keep;
    logic        last;
} exp_beat_t;

// Doorbell fields known to the model are TID, FTYPE and information
localparam logic [63:0] DB_MASK  = 64'hFFF0_0000_FFFF_0000;
// Header fields are TID, FTYPE, TTYPE, size and address
localparam logic [63:0] HDR_MASK = 64'hFFFF_0FF3_FFFF_FFFF;

exp_beat_t exp_q[$];
logic      model_alt = 1'b0;
int        error_cnt = 0;
int        check_cnt = 0;
string     cur_test  = "";
db_info_t  sent_info;
event      db_sent;

task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    assert (exp === act) else begin
        error_cnt++;
        $display("mismatch %s %s expected %0h actual %0h", cur_test, what, exp, act);
    end
endtask

task automatic check_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
        error_cnt++;
        $display("error in %s: %s", cur_test, what);
    end
endtask

task automatic push_beat(input logic [63:0] data, input logic [63:0] mask,
                         input logic [7:0] keep, input logic chk_keep, input logic last);
    exp_q.push_back({data, mask, keep, chk_keep, last});
endtask

task automatic expect_doorbell(input db_info_t info);
    push_beat({8'h00, FTYPE_DOORBELL, 20'h0, info, 16'h0}, DB_MASK, 8'h00, 1'b0, 1'b1);
endtask

// TID low bit and target address follow the model's alternating bit
task automatic expect_header(input logic [7:0] size, input srio_keep_t keep);
    push_beat({7'h00, model_alt, FTYPE_NWRITE, TTYPE_NWRITE, 4'h0, size, 2'b00,
               model_alt ? TARGET_ADDR_ODD : TARGET_ADDR_EVEN}, HDR_MASK, keep, 1'b1, 1'b0);
endtask

// Called for every ireq transfer seen by the monitor
task automatic check_beat();
    exp_beat_t e;
    check_true(exp_q.size() != 0, "ireq beat sent while the model expected none");
    if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_value("ireq data", e.data & e.mask, ireq_tdata_o & e.mask);
        check_value("ireq last", 64'(e.last), 64'(ireq_tlast_o));
        if (e.chk_keep) begin
            check_value("ireq keep", 64'(e.keep), 64'(ireq_tkeep_o));
        end
        if (e.mask == DB_MASK) begin
            sent_info = ireq_tdata_o[31:16];
            -> db_sent;
        end
    end
    check_value("ireq tuser", 64'({SRC_ID, DES_ID}), 64'(ireq_tuser_o));
endtask

// ==== tb_db_req.sv ====
// Testbench top for the RapidIO request controller
// Clock, reset, random stimulus, doorbell responder and watchdog

`timescale 1ns/1ps

module tb_db_req import srio_pkg::*, req_ctrl_pkg::*; ();

    localparam int TIMEOUT_CYCLES  = 64;
    localparam int FIFO_DEPTH      = 16;
    localparam int NUM_TESTS       = 10;
    localparam int MAX_LEN         = 20;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAX_LEN + 2 * TIMEOUT_CYCLES + 50);
    localparam dev_id_t SRC_ID     = 16'h0012;
    localparam dev_id_t DES_ID     = 16'h0034;

    logic       log_clk;
    logic       log_rst;
    dev_id_t    src_id_i;
    dev_id_t    des_id_i;
    logic       self_check_i;
    logic       nwr_req_i;
    logic       link_initialized_i;
    logic       user_tvalid_i;
    logic       user_tfirst_i;
    logic       user_tlast_i;
    srio_data_t user_tdata_i;
    srio_keep_t user_tkeep_i;
    logic [7:0] user_tsize_i;
    logic       user_tready_o;
    logic       rapidio_ready_o;
    logic       nwr_ready_o;
    logic       nwr_busy_o;
    logic       nwr_ack_done_o;
    logic       error_o;
    err_type_t  error_type_o;
    logic       ireq_tvalid_o;
    logic       ireq_tready_i  = 1'b0;
    logic       ireq_tlast_o;
    srio_data_t ireq_tdata_o;
    srio_keep_t ireq_tkeep_o;
    srio_user_t ireq_tuser_o;
    logic       iresp_tvalid_i = 1'b0;
    logic       iresp_tready_o;
    logic       iresp_tlast_i  = 1'b1;
    srio_data_t iresp_tdata_i  = '0;
    srio_keep_t iresp_tkeep_i  = 8'hFF;
    srio_user_t iresp_tuser_i  = '0;

    integer     seed = 68;
    srio_data_t pkt_data [MAX_LEN];
    srio_keep_t pkt_keep [MAX_LEN];
    srio_keep_t pkt_hdr_keep;
    logic [7:0] pkt_size;
    int         pkt_len;
    db_info_t   self_reply;
    logic       resp_silent;

    `include "tb_checks.svh"

    db_req_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)) UUT (.*);

    initial begin
        log_clk = 1'b0;
        forever #2 log_clk = ~log_clk;
    end

    always @(posedge log_clk) begin
        ireq_tready_i <= (($random(seed) & 3) != 0);
    end

    // Outputs are sampled at the falling edge, half a cycle before the transfer edge
    always @(negedge log_clk) begin
        if (!log_rst && ireq_tvalid_o && ireq_tready_i) begin
            check_beat();
        end
    end

    // Target endpoint answers a self-check as told and echoes any other doorbell
    always begin : responder
        int delay;
        @(db_sent);
        if (!resp_silent) begin
            delay = 1 + ({$random(seed)} % 16);
            repeat (delay) @(posedge log_clk);
            iresp_tvalid_i <= 1'b1;
            iresp_tuser_i  <= {DES_ID, SRC_ID};
            iresp_tdata_i  <= {8'h00, FTYPE_DOORBELL, 20'h0,
                               (sent_info == DB_INFO_SELF_CHECK) ? self_reply : sent_info, 16'h0};
            @(posedge log_clk);
            iresp_tvalid_i <= 1'b0;
        end
    end

    task automatic wait_idle();
        @(negedge log_clk);
        while (!rapidio_ready_o) @(negedge log_clk);
    endtask

    task automatic run_self_check(input string name, input db_info_t reply, input logic silent);
        cur_test    = name;
        self_reply  = reply;
        resp_silent = silent;
        wait_idle();
        expect_doorbell(DB_INFO_SELF_CHECK);
        @(posedge log_clk) self_check_i <= 1'b1;
        @(posedge log_clk) self_check_i <= 1'b0;
        @(negedge log_clk);
        while (!(error_o || nwr_ready_o || nwr_busy_o)) @(negedge log_clk);
        check_value("error_o", 64'(silent), 64'(error_o));
        if (silent) begin
            check_value("error_type_o", 64'(ERR_DB_TIMEOUT), 64'(error_type_o));
        end else begin
            check_value("nwr_ready_o", 64'(reply == DB_INFO_READY), 64'(nwr_ready_o));
            check_value("nwr_busy_o", 64'(reply == DB_INFO_BUSY), 64'(nwr_busy_o));
        end
        check_true(exp_q.size() == 0, "self-check doorbell was never sent");
    endtask

    // Header word carries only the size, payload words follow
    task automatic write_packet();
        for (int i = 0; i <= pkt_len; i++) begin
            @(posedge log_clk);
            user_tvalid_i <= 1'b1;
            user_tfirst_i <= (i == 0);
            user_tlast_i  <= (i == pkt_len);
            user_tsize_i  <= pkt_size;
            if (i == 0) begin
                user_tdata_i <= {$random(seed), $random(seed)};
                user_tkeep_i <= pkt_hdr_keep;
            end else begin
                user_tdata_i <= pkt_data[i-1];
                user_tkeep_i <= pkt_keep[i-1];
            end
            @(negedge log_clk);
            while (!user_tready_o) @(negedge log_clk);
        end
        @(posedge log_clk);
        user_tvalid_i <= 1'b0;
    endtask

    task automatic pulse_nwr();
        @(posedge log_clk) nwr_req_i <= 1'b1;
        @(posedge log_clk) nwr_req_i <= 1'b0;
    endtask

    task automatic run_nwrite(input string name, input int len, input logic silent,
                              input logic overflow);
        cur_test     = name;
        resp_silent  = silent;
        pkt_len      = len;
        pkt_size     = 8'(len * 8 - 1);
        pkt_hdr_keep = 8'($random(seed));
        wait_idle();
        expect_header(pkt_size, pkt_hdr_keep);
        for (int i = 0; i < len; i++) begin
            pkt_data[i] = {$random(seed), $random(seed)};
            pkt_keep[i] = 8'($random(seed));
            push_beat(pkt_data[i], '1, pkt_keep[i], 1'b1, i == len - 1);
        end
        expect_doorbell(model_alt ? DB_INFO_CONFIRM_ODD : DB_INFO_CONFIRM_EVEN);
        if (overflow) begin
            // The NWRITE starts only once the FIFO has filled up
            fork
                write_packet();
                begin
                    @(negedge log_clk);
                    while (user_tready_o) @(negedge log_clk);
                    pulse_nwr();
                end
            join
        end else begin
            write_packet();
            pulse_nwr();
        end
        @(negedge log_clk);
        while (!(nwr_ack_done_o || error_o)) @(negedge log_clk);
        check_value("nwr_ack_done_o", 64'(!silent), 64'(nwr_ack_done_o));
        check_value("error_o", 64'(silent), 64'(error_o));
        if (silent) begin
            check_value("error_type_o", 64'(ERR_ACK_TIMEOUT), 64'(error_type_o));
        end else begin
            model_alt = ~model_alt;
        end
        check_true(exp_q.size() == 0, "beats expected by the model were never sent");
    endtask

    initial begin : main
        log_rst            = 1'b1;
        src_id_i           = SRC_ID;
        des_id_i           = DES_ID;
        self_check_i       = 1'b0;
        nwr_req_i          = 1'b0;
        link_initialized_i = 1'b1;
        user_tvalid_i      = 1'b0;
        user_tfirst_i      = 1'b0;
        user_tlast_i       = 1'b0;
        user_tdata_i       = '0;
        user_tkeep_i       = '0;
        user_tsize_i       = '0;
        self_reply         = DB_INFO_READY;
        resp_silent        = 1'b0;
        repeat (3) @(posedge log_clk);
        log_rst <= 1'b0;
        @(negedge log_clk);
        cur_test = "reset";
        check_value("idle outputs", 64'(8'b00000111),
                    64'({ireq_tvalid_o, nwr_ready_o, nwr_busy_o, nwr_ack_done_o, error_o,
                         user_tready_o, rapidio_ready_o, iresp_tready_o}));
        run_self_check("self_check_ready", DB_INFO_READY, 1'b0);
        run_self_check("self_check_busy", DB_INFO_BUSY, 1'b0);
        run_self_check("self_check_silent", DB_INFO_READY, 1'b1);
        for (int i = 0; i < NUM_TESTS - 4; i++) begin
            run_nwrite($sformatf("nwrite_%0d", i), 1 + ({$random(seed)} % 12), i == 2, 1'b0);
        end
        run_nwrite("nwrite_overflow", MAX_LEN, 1'b0, 1'b1);
        $display("checks %0d errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge log_clk);
        $display("timeout: the DUT did not finish the tests within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("checks %0d errors %0d", check_cnt, error_cnt);
        $display("test failed");
        $finish;
    end

endmodule

// ==== user_data_fifo.sv ====
// First-word-fall-through FIFO for user header and payload beats
// Stores each word with its first, keep and last flags

`timescale 1ns/1ps

module user_data_fifo import srio_pkg::*; #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic       log_clk,
    input  logic       log_rst,
    input  logic       wr_en_i,
    input  logic       wr_first_i,
    input  logic       wr_last_i,
    input  srio_data_t wr_data_i,
    input  srio_keep_t wr_keep_i,
    input  logic       rd_en_i,
    output logic       full_o,
    output logic       empty_o,
    output logic       rd_first_o,
    output logic       rd_last_o,
    output srio_data_t rd_data_o,
    output srio_keep_t rd_keep_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    srio_data_t data_mem  [FIFO_DEPTH];
    srio_keep_t keep_mem  [FIFO_DEPTH];
    logic       first_mem [FIFO_DEPTH];
    logic       last_mem  [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge log_clk) begin
        if (wr_en_i) begin
            data_mem[wr_ptr]  <= wr_data_i;
            keep_mem[wr_ptr]  <= wr_keep_i;
            first_mem[wr_ptr] <= wr_first_i;
            last_mem[wr_ptr]  <= wr_last_i;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en_i && !rd_en_i) begin
                count <= count + 1'b1;
            end else if (rd_en_i && !wr_en_i) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);

    // Head entry is always on the outputs
    assign rd_data_o  = data_mem[rd_ptr];
    assign rd_keep_o  = keep_mem[rd_ptr];
    assign rd_first_o = first_mem[rd_ptr];
    assign rd_last_o  = last_mem[rd_ptr];

    a_no_overflow: assert property (@(posedge log_clk) disable iff (log_rst)
        !(wr_en_i && full_o));

    a_no_underflow: assert property (@(posedge log_clk) disable iff (log_rst)
        !(rd_en_i && empty_o));

endmodule
